/* host_map_pkg.sv */
package host_map_pkg;

    ////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////

    // apb address and data widths
    localparam int apb_addr_w = 8, apb_data_w = 16;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    // staging words, low and high half of a 32-bit parameter
    localparam logic [apb_addr_w-1:0] addr_stage_lo = 8'h01, addr_stage_hi = 8'h02;

    // trigger word, write-only pulses
    localparam logic [apb_addr_w-1:0] addr_trigger = 8'h50;

    // active half-count readback
    localparam logic [apb_addr_w-1:0] addr_half_cnt_lo = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_half_cnt_hi = 8'h09;

    // per-window spike totals, same endpoints as the old wire-outs
    localparam logic [apb_addr_w-1:0] addr_sn_cnt_lo = 8'h24;
    localparam logic [apb_addr_w-1:0] addr_sn_cnt_hi = 8'h25;
    localparam logic [apb_addr_w-1:0] addr_mn_cnt_lo = 8'h26;
    localparam logic [apb_addr_w-1:0] addr_mn_cnt_hi = 8'h27;

    ////////////////////////////////////////
    // trigger bits and reset values
    ////////////////////////////////////////

    // bit 0 of the trigger word loads the half-count
    localparam int trig_half_cnt = 0;

    // window half-count after reset, gives a 20-cycle window
    localparam int unsigned half_cnt_default = 9;

    // staging words come up cleared
    localparam logic [apb_data_w-1:0] stage_default = '0;

endpackage

/* spike_pkg.sv */
package spike_pkg;

    ////////////////////////////////////////
    // count words
    ////////////////////////////////////////

    // width of a spike total and of the window half-count
    localparam int count_w = 32;

    // one half as seen by a 16-bit host read
    localparam int count_half_w = count_w / 2;

    // one count, written raw by the counter
    // and read back by halves on the host side
    typedef union packed {
        logic [count_w-1:0] raw;
        struct packed {
            logic [count_half_w-1:0] hi;
            logic [count_half_w-1:0] lo;
        } half;
    } count_word_u;

    ////////////////////////////////////////
    // status leds
    ////////////////////////////////////////

    // board has 8 leds, all active low
    localparam int led_w = 8;

    // bit positions
    localparam int led_reset    = 1;
    localparam int led_sn_spike = 3;
    localparam int led_mn_spike = 4;
    localparam int led_sim_clk  = 7;

endpackage

/* apb_if.sv */
interface apb_if;
    import host_map_pkg::*;

    // request side, driven by the host
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_data_w-1:0] pwdata;

    // completion side, driven by the register block
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // host end
    modport master
    (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    // register block end
    modport slave
    (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pready, pslverr
    );

endinterface

/* count_if.sv */
interface count_if;
    import spike_pkg::*;

    // one-cycle strobe at the end of each window
    logic        window_end;
    // slow simulation clock level
    logic        sim_clk;

    // latched per-window totals
    count_word_u sn_count;
    count_word_u mn_count;

    // timer drives the window side
    modport timer
    (
        output window_end, sim_clk
    );

    // register block only reads the totals
    modport host
    (
        input sn_count, mn_count
    );

endinterface

/* window_timer.sv */
module window_timer
(
    input  logic                          ep50trig,
    input  logic                          reset_sim,
    input  logic [spike_pkg::count_w-1:0] i_half_cnt,
    count_if.timer                        cnt
);
    import spike_pkg::*;

    logic [count_w-1:0] div_cnt;
    logic               div_wrap;
    logic               sim_clk_q;
    logic               window_end_q;

    // wrap at the half-count
    // >= so a smaller reload ends the current half at once
    assign div_wrap = (div_cnt >= i_half_cnt);

    ////////////////////////////////////////
    // half-period divider
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            div_cnt      <= '0;
            sim_clk_q    <= 1'b0;
            window_end_q <= 1'b0;
        end
        else
        begin
            if (div_wrap)
            begin
                div_cnt   <= '0;
                // toggle the slow clock on every wrap
                sim_clk_q <= ~sim_clk_q;
            end
            else
            begin
                div_cnt <= div_cnt + count_w'(1);
            end
            // window closes on the wrap that ends the high half
            window_end_q <= div_wrap & sim_clk_q;
        end
    end

    assign cnt.sim_clk    = sim_clk_q;
    assign cnt.window_end = window_end_q;

endmodule

/* spike_counter.sv */
module spike_counter
(
    input  logic                   ep50trig,
    input  logic                   reset_sim,
    input  logic                   i_spike,
    input  logic                   i_window_end,
    output spike_pkg::count_word_u o_count,
    output logic                   o_spike_seen
);
    import spike_pkg::*;

    logic               spike_q;
    logic               spike_prev;
    logic               spike_edge;
    logic [count_w-1:0] run_cnt;
    count_word_u        count_q;

    // input register, then one more stage for the edge
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            spike_q    <= 1'b0;
            spike_prev <= 1'b0;
        end
        else
        begin
            spike_q    <= i_spike;
            spike_prev <= spike_q;
        end
    end

    // rising edge of the registered spike
    assign spike_edge = spike_q & ~spike_prev;

    ////////////////////////////////////////
    // running count and window latch
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            run_cnt     <= '0;
            count_q.raw <= '0;
        end
        else if (i_window_end)
        begin
            // edge on the strobe cycle still belongs to the closing window
            count_q.raw <= run_cnt + count_w'(spike_edge);
            run_cnt     <= '0;
        end
        else
        begin
            // plain wrap past 2^32, no saturation
            run_cnt <= run_cnt + count_w'(spike_edge);
        end
    end

    assign o_count      = count_q;
    assign o_spike_seen = spike_q;

endmodule

/* host_regs.sv */
module host_regs
(
    input  logic                          ep50trig,
    input  logic                          reset_sim,
    apb_if.slave                          bus,
    count_if.host                         cnt,
    output logic [spike_pkg::count_w-1:0] o_half_cnt
);
    import host_map_pkg::*;
    import spike_pkg::*;

    logic [apb_data_w-1:0] stage_lo;
    logic [apb_data_w-1:0] stage_hi;
    logic [count_w-1:0]    half_cnt;
    logic                  trig_q;

    logic                  addr_hit;
    logic                  addr_ro;
    logic [apb_data_w-1:0] rd_word;

    logic                  setup_ph;
    logic                  access_ph;
    logic                  wr_en;

    logic [apb_data_w-1:0] prdata_q;
    logic                  pready_q;
    logic                  pslverr_q;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    always_comb
    begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        rd_word  = '0;
        case (bus.paddr)
            addr_stage_lo:
                rd_word = stage_lo;
            addr_stage_hi:
                rd_word = stage_hi;
            // trigger reads back as zero
            addr_trigger:
                rd_word = '0;
            addr_half_cnt_lo:
            begin
                rd_word = half_cnt[apb_data_w-1:0];
                addr_ro = 1'b1;
            end
            addr_half_cnt_hi:
            begin
                rd_word = half_cnt[count_w-1:apb_data_w];
                addr_ro = 1'b1;
            end
            // totals split through the union
            addr_sn_cnt_lo:
            begin
                rd_word = cnt.sn_count.half.lo;
                addr_ro = 1'b1;
            end
            addr_sn_cnt_hi:
            begin
                rd_word = cnt.sn_count.half.hi;
                addr_ro = 1'b1;
            end
            addr_mn_cnt_lo:
            begin
                rd_word = cnt.mn_count.half.lo;
                addr_ro = 1'b1;
            end
            addr_mn_cnt_hi:
            begin
                rd_word = cnt.mn_count.half.hi;
                addr_ro = 1'b1;
            end
            default:
                addr_hit = 1'b0;
        endcase
    end

    // apb phases
    assign setup_ph  = bus.psel & ~bus.penable;
    assign access_ph = bus.psel & bus.penable;

    // writes land at the end of the access phase, never on read-only words
    assign wr_en = access_ph & bus.pwrite & addr_hit & ~addr_ro;

    ////////////////////////////////////////
    // staging words and half-count
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            stage_lo <= stage_default;
            stage_hi <= stage_default;
            trig_q   <= 1'b0;
        end
        else
        begin
            if (wr_en && bus.paddr == addr_stage_lo)
                stage_lo <= bus.pwdata;
            if (wr_en && bus.paddr == addr_stage_hi)
                stage_hi <= bus.pwdata;
            // one-cycle trigger pulse, like the old ep50 trigger bit
            trig_q <= wr_en && (bus.paddr == addr_trigger) && bus.pwdata[trig_half_cnt];
        end
    end

    // load staged 32 bits the cycle after the trigger
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            half_cnt <= count_w'(half_cnt_default);
        else if (trig_q)
            half_cnt <= {stage_hi, stage_lo};
    end

    ////////////////////////////////////////
    // completion
    ////////////////////////////////////////

    // read data and error captured in setup, valid through access
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
            prdata_q  <= '0;
        end
        else
        begin
            // no wait states
            pready_q <= 1'b1;
            if (setup_ph)
            begin
                prdata_q  <= bus.pwrite ? '0 : rd_word;
                pslverr_q <= ~addr_hit | (bus.pwrite & addr_ro);
            end
            else
            begin
                pslverr_q <= 1'b0;
            end
        end
    end

    assign bus.prdata  = prdata_q;
    assign bus.pready  = pready_q;
    assign bus.pslverr = pslverr_q;
    assign o_half_cnt  = half_cnt;

endmodule

/* one_joint_monitor.sv */
module one_joint_monitor
(
    input  logic                              ep50trig,
    input  logic                              reset_sim,
    input  logic [host_map_pkg::apb_addr_w-1:0] i_paddr,
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  logic [host_map_pkg::apb_data_w-1:0] i_pwdata,
    output logic [host_map_pkg::apb_data_w-1:0] o_prdata,
    output logic                              o_pready,
    output logic                              o_pslverr,
    input  logic                              i_spike_sn,
    input  logic                              i_spike_mn,
    output logic [spike_pkg::led_w-1:0]       o_led,
    output logic                              o_sim_clk
);
    import spike_pkg::*;

    apb_if   apb_bus ();
    count_if cnt_bus ();

    logic [count_w-1:0] half_cnt;
    logic               sn_seen;
    logic               mn_seen;
    logic [led_w-1:0]   led_on;

    ////////////////////////////////////////
    // host bus
    ////////////////////////////////////////

    assign apb_bus.paddr   = i_paddr;
    assign apb_bus.psel    = i_psel;
    assign apb_bus.penable = i_penable;
    assign apb_bus.pwrite  = i_pwrite;
    assign apb_bus.pwdata  = i_pwdata;

    assign o_prdata  = apb_bus.prdata;
    assign o_pready  = apb_bus.pready;
    assign o_pslverr = apb_bus.pslverr;

    host_regs regs
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .bus        (apb_bus.slave),
        .cnt        (cnt_bus.host),
        .o_half_cnt (half_cnt)
    );

    ////////////////////////////////////////
    // window and spike bookkeeping
    ////////////////////////////////////////

    window_timer timer
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_half_cnt (half_cnt),
        .cnt        (cnt_bus.timer)
    );

    // sensory Ia channel
    spike_counter sn_counter
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_spike      (i_spike_sn),
        .i_window_end (cnt_bus.window_end),
        .o_count      (cnt_bus.sn_count),
        .o_spike_seen (sn_seen)
    );

    // motor neuron channel
    spike_counter mn_counter
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_spike      (i_spike_mn),
        .i_window_end (cnt_bus.window_end),
        .o_count      (cnt_bus.mn_count),
        .o_spike_seen (mn_seen)
    );

    // leds, lit when low, unused ones dark
    always_comb
    begin
        led_on               = '0;
        led_on[led_reset]    = reset_sim;
        led_on[led_sn_spike] = sn_seen;
        led_on[led_mn_spike] = mn_seen;
        led_on[led_sim_clk]  = cnt_bus.sim_clk;
    end

    assign o_led     = ~led_on;
    assign o_sim_clk = cnt_bus.sim_clk;

endmodule

/* tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

////////////////////////////////////////
// host bus access
////////////////////////////////////////

// one apb write, setup then access, pslverr expectation set up front
task automatic apb_write(input logic [7:0] addr, input logic [15:0] data, input logic err);
    @(posedge ep50trig);
    exp_err = err;
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge ep50trig);
    penable <= 1'b1;
    // access phase sampled here
    @(posedge ep50trig);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

// one apb read, data taken in the access phase
task automatic apb_read(input logic [7:0] addr, input logic err, output logic [15:0] data);
    @(posedge ep50trig);
    exp_err = err;
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge ep50trig);
    penable <= 1'b1;
    @(posedge ep50trig);
    data = prdata;
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

////////////////////////////////////////
// spike stimulus
////////////////////////////////////////

// n one-cycle pulses on one channel, random low gaps of 1 or 2 cycles
task automatic spike_burst(input logic mn, input int n);
    int gap;
    // keep clear of the window start
    repeat (2) @(posedge ep50trig);
    for (int i = 0; i < n; i++)
    begin
        gap = 1 + (($random(seed) & 32'h7fffffff) % 2);
        @(posedge ep50trig);
        if (mn)
            spike_mn <= 1'b1;
        else
            spike_sn <= 1'b1;
        @(posedge ep50trig);
        if (mn)
            spike_mn <= 1'b0;
        else
            spike_sn <= 1'b0;
        repeat (gap - 1) @(posedge ep50trig);
    end
endtask

`endif

/* one_joint_monitor_tb.sv */
module one_joint_monitor_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import host_map_pkg::*;
    import spike_pkg::*;

    // rough cycle budget of all tests together
    localparam int test_cycles = 320;

    logic ep50trig;
    logic reset_sim;
    logic [7:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic pready;
    logic pslverr;
    logic spike_sn;
    logic spike_mn;
    logic [7:0] led;
    logic sim_clk;

    int seed = 32'h7227335f;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_mark;
    int cyc;
    int last_rise;
    int rise_cnt;
    logic sim_clk_d;
    logic exp_err;
    logic period_chk;

    one_joint_monitor i_dut
    (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_paddr   (paddr),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr),
        .i_spike_sn(spike_sn),
        .i_spike_mn(spike_mn),
        .o_led     (led),
        .o_sim_clk (sim_clk)
    );

    `include "tb_apb_tasks.svh"

    // 40 ns period
    always #20 ep50trig = ~ep50trig;

    // cycles since reset release, and slow clock rises
    always @(posedge ep50trig)
    begin
        sim_clk_d <= sim_clk;
        if (reset_sim)
        begin
            cyc      <= 0;
            rise_cnt <= 0;
        end
        else
        begin
            cyc <= cyc + 1;
            if (sim_clk && !sim_clk_d)
            begin
                rise_cnt  <= rise_cnt + 1;
                last_rise <= cyc;
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // only led 1 lit while reset held
    assert property (@(posedge ep50trig) reset_sim |-> led == 8'hfd)
    else
    begin
        $display("FAIL o_led got %h expected fd", $sampled(led));
        errors = errors + 1;
    end

    // setup always followed by a ready access phase
    assert property (@(posedge ep50trig) disable iff (reset_sim)
        (psel && !penable) |=> (psel && penable && pready))
    else
    begin
        $display("apb access did not complete in two cycles with pready high");
        errors = errors + 1;
    end

    assert property (@(posedge ep50trig) disable iff (reset_sim)
        (psel && penable) |-> pslverr == exp_err)
    else
    begin
        $display("FAIL o_pslverr got %h expected %h", $sampled(pslverr), exp_err);
        errors = errors + 1;
    end

    // first slow clock rise 10 cycles after release
    assert property (@(posedge ep50trig) disable iff (reset_sim)
        ($rose(sim_clk) && rise_cnt == 0) |-> cyc == 10)
    else
    begin
        $display("FAIL o_sim_clk first rise at cycle %h expected %h", $sampled(cyc), 10);
        errors = errors + 1;
    end

    assert property (@(posedge ep50trig) disable iff (reset_sim)
        ($rose(sim_clk) && rise_cnt != 0 && period_chk) |-> cyc - last_rise == 20)
    else
    begin
        $display("FAIL o_sim_clk period got %h expected %h",
                 $sampled(cyc) - $sampled(last_rise), 20);
        errors = errors + 1;
    end

    // spike leds follow the inputs one cycle late
    assert property (@(posedge ep50trig) disable iff (reset_sim)
        $rose(spike_sn) |=> !led[led_sn_spike])
    else
    begin
        $display("sn spike led did not light one cycle after the spike rose");
        errors = errors + 1;
    end

    assert property (@(posedge ep50trig) disable iff (reset_sim)
        $fell(spike_sn) |=> led[led_sn_spike])
    else
    begin
        $display("sn spike led did not go dark one cycle after the spike fell");
        errors = errors + 1;
    end

    assert property (@(posedge ep50trig) disable iff (reset_sim)
        $rose(spike_mn) |=> !led[led_mn_spike])
    else
    begin
        $display("mn spike led did not light one cycle after the spike rose");
        errors = errors + 1;
    end

    assert property (@(posedge ep50trig) disable iff (reset_sim)
        $fell(spike_mn) |=> led[led_mn_spike])
    else
    begin
        $display("mn spike led did not go dark one cycle after the spike fell");
        errors = errors + 1;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // returns at the edge where window_end is seen, counts latch here
    task automatic wait_window_end(output int at);
        do
            @(posedge ep50trig);
        while (!(sim_clk_d && !sim_clk));
        at = cyc;
    endtask

    task automatic close_test(input string name);
        tests_run = tests_run + 1;
        if (errors != err_mark)
            tests_failed = tests_failed + 1;
        $display("test %0d %s: %s", tests_run, name, (errors != err_mark) ? "failed" : "ok");
        err_mark = errors;
    endtask

    // watchdog, twice the budget
    initial
    begin
        #(test_cycles * 2 * 40);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // sequence
    ////////////////////////////////////////

    initial
    begin
        logic [15:0] rd;
        int n_sn;
        int n_mn;
        int t0;
        int t1;
        ep50trig   = 1'b0;
        reset_sim  = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        spike_sn   = 1'b0;
        spike_mn   = 1'b0;
        exp_err    = 1'b0;
        period_chk = 1'b0;
        err_mark   = 0;

        // reset state and default window
        repeat (2) @(posedge ep50trig);
        reset_sim <= 1'b0;
        apb_read(addr_half_cnt_lo, 1'b0, rd);
        check_value("o_prdata half_cnt_lo", 32'(rd), 32'(half_cnt_default));
        apb_read(addr_half_cnt_hi, 1'b0, rd);
        check_value("o_prdata half_cnt_hi", 32'(rd), 32'h0);
        while (rise_cnt < 1)
            @(posedge ep50trig);
        period_chk = 1'b1;
        while (rise_cnt < 3)
            @(posedge ep50trig);
        close_test("reset state");

        // per-window counts, channels chosen independently
        n_sn = 1 + (($random(seed) & 32'h7fffffff) % 4);
        n_mn = 1 + (($random(seed) & 32'h7fffffff) % 4);
        wait_window_end(t0);
        fork
            spike_burst(1'b0, n_sn);
            spike_burst(1'b1, n_mn);
        join
        wait_window_end(t0);
        apb_read(addr_sn_cnt_lo, 1'b0, rd);
        check_value("o_prdata sn_cnt_lo", 32'(rd), 32'(n_sn));
        apb_read(addr_sn_cnt_hi, 1'b0, rd);
        check_value("o_prdata sn_cnt_hi", 32'(rd), 32'h0);
        apb_read(addr_mn_cnt_lo, 1'b0, rd);
        check_value("o_prdata mn_cnt_lo", 32'(rd), 32'(n_mn));
        apb_read(addr_mn_cnt_hi, 1'b0, rd);
        check_value("o_prdata mn_cnt_hi", 32'(rd), 32'h0);
        close_test("per-window counts");

        // protocol, staging readback and error cases
        // the window closing here held no spikes
        wait_window_end(t0);
        apb_write(addr_sn_cnt_lo, 16'hbeef, 1'b1);
        apb_read(addr_sn_cnt_lo, 1'b0, rd);
        check_value("o_prdata sn_cnt_lo after write", 32'(rd), 32'h0);
        apb_read(8'h77, 1'b1, rd);
        apb_write(addr_stage_lo, 16'h5a3c, 1'b0);
        apb_write(addr_stage_hi, 16'hc3a5, 1'b0);
        apb_read(addr_stage_lo, 1'b0, rd);
        check_value("o_prdata stage_lo", 32'(rd), 32'h5a3c);
        apb_read(addr_stage_hi, 1'b0, rd);
        check_value("o_prdata stage_hi", 32'(rd), 32'hc3a5);
        close_test("apb protocol");

        // an empty window after a counted one reads zero
        wait_window_end(t0);
        fork
            spike_burst(1'b0, n_sn);
            spike_burst(1'b1, n_mn);
        join
        wait_window_end(t0);
        wait_window_end(t0);
        apb_read(addr_sn_cnt_lo, 1'b0, rd);
        check_value("o_prdata sn_cnt_lo empty", 32'(rd), 32'h0);
        apb_read(addr_mn_cnt_lo, 1'b0, rd);
        check_value("o_prdata mn_cnt_lo empty", 32'(rd), 32'h0);
        close_test("window restart");

        // led follow, different lengths per channel
        @(posedge ep50trig);
        spike_sn <= 1'b1;
        spike_mn <= 1'b1;
        repeat (2) @(posedge ep50trig);
        spike_mn <= 1'b0;
        repeat (2) @(posedge ep50trig);
        spike_sn <= 1'b0;
        repeat (3) @(posedge ep50trig);
        close_test("spike leds");

        // staging alone keeps the 20-cycle window
        period_chk = 1'b0;
        apb_write(addr_stage_lo, 16'h0004, 1'b0);
        apb_write(addr_stage_hi, 16'h0000, 1'b0);
        wait_window_end(t0);
        wait_window_end(t1);
        check_value("window length before trigger", 32'(t1 - t0), 32'd20);
        apb_write(addr_trigger, 16'h0001 << trig_half_cnt, 1'b0);
        apb_read(addr_half_cnt_lo, 1'b0, rd);
        check_value("o_prdata half_cnt_lo loaded", 32'(rd), 32'h4);
        apb_read(addr_half_cnt_hi, 1'b0, rd);
        check_value("o_prdata half_cnt_hi loaded", 32'(rd), 32'h0);
        wait_window_end(t0);
        wait_window_end(t0);
        wait_window_end(t1);
        check_value("window length after trigger", 32'(t1 - t0), 32'd10);
        close_test("half-count load");

        $display("tests run %0d, failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
host_map_pkg.sv
spike_pkg.sv
apb_if.sv
count_if.sv
window_timer.sv
spike_counter.sv
host_regs.sv
one_joint_monitor.sv
one_joint_monitor_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator and run, pass decided from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module one_joint_monitor_tb \
    -f sim.f -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb 2>&1 | tee sim.log

grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
